// ==== logic/gps_pkg.sv ====
`default_nettype none

package gps_pkg;

   // One baseband sample, sign-magnitude
   typedef struct packed {
      logic       sign;            // Set for a negative sample
      logic [1:0] mag;             // Magnitude 0 to 3
   } baseband_t;

   // Position within the code period
   typedef struct packed {
      logic [9:0] chip;            // Chip index 0 to 1022
      logic [3:0] sub;             // Sample within the chip
   } code_phase_t;

   typedef logic signed [15:0] acc_t;   // Correlation sum

   localparam int CA_LEN = 1023;        // Chips per code period

   // G2 phase selector stages per PRN, {stage_a, stage_b}
   localparam logic [7:0] G2_TAPS [1:32] = '{
      8'h26, 8'h37, 8'h48, 8'h59,      // PRN 1 to 4
      8'h19, 8'h2A, 8'h18, 8'h29,      // PRN 5 to 8
      8'h3A, 8'h23, 8'h34, 8'h56,      // PRN 9 to 12
      8'h67, 8'h78, 8'h89, 8'h9A,      // PRN 13 to 16
      8'h14, 8'h25, 8'h36, 8'h47,      // PRN 17 to 20
      8'h58, 8'h69, 8'h13, 8'h46,      // PRN 21 to 24
      8'h57, 8'h68, 8'h79, 8'h8A,      // PRN 25 to 28
      8'h16, 8'h27, 8'h38, 8'h49       // PRN 29 to 32
   };

endpackage

`default_nettype wire

// ==== logic/hex_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_driver (
   input  logic [3:0] value,          // Nibble to show
   input  logic       blank,          // Turn all segments off
   output logic [6:0] seg             // Segments g to a, active low
);

   always_comb begin
      unique case (value)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'hA: seg = 7'h08;
         4'hB: seg = 7'h03;           // Lower case b
         4'hC: seg = 7'h46;
         4'hD: seg = 7'h21;           // Lower case d
         4'hE: seg = 7'h06;
         default: seg = 7'h0E;        // F
      endcase
      if (blank) begin
         seg = 7'h7F;                 // Everything dark
      end
   end

endmodule

`default_nettype wire

// ==== logic/ca_code_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ca_code_gen import gps_pkg::*; (
   input  logic       clk_sample,
   input  logic       arst_n,
   input  logic [4:0] prn,          // Satellite select, taken after reset
   input  logic       chip_adv,     // Step to the next chip
   output logic       ca_bit,       // Current chip
   output logic       last_chip     // Chip 1022 is on the output
);

   logic [10:1] g1;                 // G1 register, stage 1 on the right
   logic [10:1] g2;                 // G2 register
   logic [9:0]  chip_cnt;           // Chip index within the period
   logic [10:1] tap_mask;           // The two selected G2 stages
   logic [10:1] tap_new;            // Mask decoded from the table
   logic [7:0]  tap_pair;           // Table entry for this PRN
   logic [4:0]  prn_idx;            // PRN kept inside the table range
   logic        tap_ld;             // Mask still to be loaded
   logic        g1_fb;
   logic        g2_fb;

   assign prn_idx = (prn == 5'd0) ? 5'd1 : prn;   // PRN 0 falls back to PRN 1

   // x^10 + x^3 + 1
   assign g1_fb = g1[3] ^ g1[10];
   // x^10 + x^9 + x^8 + x^6 + x^3 + x^2 + 1
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

   assign last_chip = (chip_cnt == 10'(CA_LEN - 1));

   // All-ones state gives chip 0 = 1 for any mask, so the mask may load late
   assign ca_bit = g1[10] ^ (^(g2 & tap_mask));

   always_comb begin
      tap_pair = G2_TAPS[prn_idx];
      tap_new  = (10'b1 << (tap_pair[7:4] - 4'd1)) |
                 (10'b1 << (tap_pair[3:0] - 4'd1));   // One bit per stage
   end

   always_ff @(posedge clk_sample or negedge arst_n) begin
      if (!arst_n) begin
         g1       <= '1;            // Both registers start all ones
         g2       <= '1;
         chip_cnt <= '0;
         tap_mask <= '0;
         tap_ld   <= 1'b1;
      end else begin
         if (tap_ld) begin
            tap_mask <= tap_new;    // PRN captured once per reset
            tap_ld   <= 1'b0;
         end
         if (chip_adv) begin
            if (last_chip) begin
               g1       <= '1;      // Reload at the period boundary
               g2       <= '1;
               chip_cnt <= '0;
            end else begin
               g1       <= {g1[9:1], g1_fb};
               g2       <= {g2[9:1], g2_fb};
               chip_cnt <= chip_cnt + 10'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/ca_upsampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module ca_upsampler import gps_pkg::*; #(
   parameter int SAMPLES_PER_CHIP = 4     // Samples per chip, 1 to 16
) (
   input  logic        clk_sample,
   input  logic        arst_n,
   input  logic [4:0]  prn,
   output logic        ca_bit,            // Chip held for the whole chip time
   output code_phase_t code_phase,        // Chip and sample position
   output logic        epoch              // Last sample of the code period
);

   localparam logic [3:0] SUB_LAST = 4'(SAMPLES_PER_CHIP - 1);
   localparam logic [9:0] CHIP_LAST = 10'(CA_LEN - 1);

   logic [3:0] sub_cnt;                   // Sample within the chip
   logic [9:0] chip_idx;                  // Chip index for code_phase
   logic       chip_adv;                  // Last sample of this chip
   logic       last_chip;                 // From the generator

   assign chip_adv = (sub_cnt == SUB_LAST);
   assign epoch    = chip_adv & last_chip;   // One cycle per period

   assign code_phase = '{chip: chip_idx, sub: sub_cnt};

   always_ff @(posedge clk_sample or negedge arst_n) begin
      if (!arst_n) begin
         sub_cnt  <= '0;
         chip_idx <= '0;
      end else begin
         if (chip_adv) begin
            sub_cnt <= '0;
            if (chip_idx == CHIP_LAST) begin
               chip_idx <= '0;            // Wrap with the code period
            end else begin
               chip_idx <= chip_idx + 10'd1;
            end
         end else begin
            sub_cnt <= sub_cnt + 4'd1;
         end
      end
   end

   // Gold code source, stepped once per chip
   ca_code_gen u_code_gen (
      .clk_sample (clk_sample),
      .arst_n     (arst_n),
      .prn        (prn),
      .chip_adv   (chip_adv),
      .ca_bit     (ca_bit),
      .last_chip  (last_chip)
   );

endmodule

`default_nettype wire

// ==== logic/code_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_correlator import gps_pkg::*; (
   input  logic      clk_sample,
   input  logic      arst_n,
   input  baseband_t baseband,        // One sample per cycle
   input  logic      ca_bit,          // Local replica chip
   input  logic      epoch,           // Last sample of the period
   output acc_t      accumulator,     // Sum of the last full period
   output logic      dump             // New sum on accumulator
);

   logic signed [2:0] mag_s;          // Magnitude as a signed value
   logic signed [2:0] term;           // Sample with the code wiped off
   acc_t              sum;            // Running sum of this period
   acc_t              sum_next;       // Sum including this sample

   // Chip 1 maps to -1, so a negative sample times chip 1 is positive
   always_comb begin
      mag_s    = $signed({1'b0, baseband.mag});
      term     = (baseband.sign ^ ca_bit) ? -mag_s : mag_s;
      sum_next = sum + acc_t'(term);  // Sign-extended add
   end

   always_ff @(posedge clk_sample or negedge arst_n) begin
      if (!arst_n) begin
         sum         <= '0;
         accumulator <= '0;
         dump        <= 1'b0;
      end else begin
         dump <= epoch;               // Pulse lines up with the new value
         if (epoch) begin
            accumulator <= sum_next;  // Includes the epoch sample
            sum         <= '0;        // Next period starts clean
         end else begin
            sum <= sum_next;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/gps_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_display import gps_pkg::*; (
   input  logic       clk_sample,
   input  logic       arst_n,
   input  acc_t       accumulator,    // Last correlation dump
   input  logic [4:0] prn,
   input  logic       view_cnt,       // Show the sample counter instead
   output logic [6:0] hex0,
   output logic [6:0] hex1,
   output logic [6:0] hex2,
   output logic [6:0] hex3,
   output logic [6:0] hex4,           // PRN units
   output logic [6:0] hex5            // PRN tens
);

   logic [15:0] sample_cnt;           // Samples since reset, wraps
   logic [15:0] view_q;               // Value on the four low digits
   logic [3:0]  prn_tens;
   logic [3:0]  prn_units;
   logic [3:0]  tens_q;
   logic [3:0]  units_q;
   logic        live;                 // Low until the first cycle after reset

   // Binary PRN to two decimal digits, 0 to 31
   always_comb begin
      if (prn >= 5'd30) begin
         prn_tens  = 4'd3;
         prn_units = 4'(prn - 5'd30);
      end else if (prn >= 5'd20) begin
         prn_tens  = 4'd2;
         prn_units = 4'(prn - 5'd20);
      end else if (prn >= 5'd10) begin
         prn_tens  = 4'd1;
         prn_units = 4'(prn - 5'd10);
      end else begin
         prn_tens  = 4'd0;
         prn_units = 4'(prn);
      end
   end

   always_ff @(posedge clk_sample or negedge arst_n) begin
      if (!arst_n) begin
         sample_cnt <= '0;
         live       <= 1'b0;
      end else begin
         sample_cnt <= sample_cnt + 16'd1;
         live       <= 1'b1;
      end
   end

   // View multiplexer register, decoders follow
   always_ff @(posedge clk_sample) begin
      view_q  <= view_cnt ? sample_cnt : accumulator;
      tens_q  <= prn_tens;
      units_q <= prn_units;
   end

   hex_driver u_hex0 (.value(view_q[3:0]),   .blank(!live), .seg(hex0));
   hex_driver u_hex1 (.value(view_q[7:4]),   .blank(!live), .seg(hex1));
   hex_driver u_hex2 (.value(view_q[11:8]),  .blank(!live), .seg(hex2));
   hex_driver u_hex3 (.value(view_q[15:12]), .blank(!live), .seg(hex3));
   hex_driver u_hex4 (.value(units_q),       .blank(!live), .seg(hex4));
   hex_driver u_hex5 (.value(tens_q),        .blank(!live), .seg(hex5));

endmodule

`default_nettype wire

// ==== logic/gps_track_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_track_top import gps_pkg::*; #(
   parameter int SAMPLES_PER_CHIP = 4     // Chip hold in samples
) (
   input  logic        clk_sample,
   input  logic        arst_n,
   input  baseband_t   baseband,          // Continuous sample stream
   input  logic [4:0]  prn,               // Satellite select
   input  logic        view_cnt,          // Display view select
   output logic        ca_bit,
   output code_phase_t code_phase,
   output logic        dump,
   output acc_t        accumulator,
   output logic [6:0]  hex0,
   output logic [6:0]  hex1,
   output logic [6:0]  hex2,
   output logic [6:0]  hex3,
   output logic [6:0]  hex4,
   output logic [6:0]  hex5
);

   logic epoch;                           // End of each code period

   // Local code replica
   ca_upsampler #(
      .SAMPLES_PER_CHIP (SAMPLES_PER_CHIP)
   ) u_upsampler (
      .clk_sample (clk_sample),
      .arst_n     (arst_n),
      .prn        (prn),
      .ca_bit     (ca_bit),
      .code_phase (code_phase),
      .epoch      (epoch)
   );

   // Integrate and dump once per period
   code_correlator u_correlator (
      .clk_sample  (clk_sample),
      .arst_n      (arst_n),
      .baseband    (baseband),
      .ca_bit      (ca_bit),
      .epoch       (epoch),
      .accumulator (accumulator),
      .dump        (dump)
   );

   gps_display u_display (
      .clk_sample  (clk_sample),
      .arst_n      (arst_n),
      .accumulator (accumulator),
      .prn         (prn),
      .view_cnt    (view_cnt),
      .hex0        (hex0),
      .hex1        (hex1),
      .hex2        (hex2),
      .hex3        (hex3),
      .hex4        (hex4),
      .hex5        (hex5)
   );

endmodule

`default_nettype wire

// ==== verif/tb_gps_track.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gps_track import gps_pkg::*; ();

   localparam int PERIOD       = 1023 * 4;       // Samples per code period at 4 per chip
   localparam int DUMP_TIMEOUT = 5000;           // Cycle bound on every dump wait

   logic        clk_sample;
   logic        arst_n;
   baseband_t   baseband;
   logic [4:0]  prn;
   logic        view_cnt;
   logic        ca_bit;
   code_phase_t code_phase;
   logic        dump;
   acc_t        accumulator;
   logic [6:0]  hex0;
   logic [6:0]  hex1;
   logic [6:0]  hex2;
   logic [6:0]  hex3;
   logic [6:0]  hex4;
   logic [6:0]  hex5;

   int cyc;                                      // Rising edges since reset release
   int seed;                                     // State of the view toggle generator
   int rnd;

   gps_track_top #(
      .SAMPLES_PER_CHIP (4)
   ) uut (
      .clk_sample  (clk_sample),
      .arst_n      (arst_n),
      .baseband    (baseband),
      .prn         (prn),
      .view_cnt    (view_cnt),
      .ca_bit      (ca_bit),
      .code_phase  (code_phase),
      .dump        (dump),
      .accumulator (accumulator),
      .hex0        (hex0),
      .hex1        (hex1),
      .hex2        (hex2),
      .hex3        (hex3),
      .hex4        (hex4),
      .hex5        (hex5)
   );

   initial begin
      clk_sample = 1'b0;
      forever #2 clk_sample = ~clk_sample;       // 4 ns period
   end

   always @(posedge clk_sample or negedge arst_n) begin
      if (!arst_n) cyc <= 0;
      else cyc <= cyc + 1;                       // Equals the DUT sample index plus one
   end

   // Standard hex glyphs on active-low segments g to a
   function automatic logic [6:0] expected_seg(input logic [3:0] nib);
      logic [6:0] glyph [16];
      glyph = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
      return glyph[nib];
   endfunction

   task automatic check_value(input string name, input int exp, input int act);
      if (exp != act) begin
         $display("ERR time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_idle();
      check_value("dump", 0, int'(dump));
      check_value("accumulator", 0, int'(accumulator));
      check_value("code_phase", 0, int'(code_phase));
      check_value("hex0", 'h7F, int'(hex0));     // Blank while in reset
      check_value("hex1", 'h7F, int'(hex1));
      check_value("hex2", 'h7F, int'(hex2));
      check_value("hex3", 'h7F, int'(hex3));
      check_value("hex4", 'h7F, int'(hex4));
      check_value("hex5", 'h7F, int'(hex5));
   endtask

   task automatic check_digits(input logic [15:0] val);
      check_value("hex0", int'(expected_seg(val[3:0])), int'(hex0));
      check_value("hex1", int'(expected_seg(val[7:4])), int'(hex1));
      check_value("hex2", int'(expected_seg(val[11:8])), int'(hex2));
      check_value("hex3", int'(expected_seg(val[15:12])), int'(hex3));
   endtask

   task automatic check_prn(input int p);
      check_value("hex4", int'(expected_seg(4'(p % 10))), int'(hex4));   // Units
      check_value("hex5", int'(expected_seg(4'(p / 10))), int'(hex5));   // Tens
   endtask

   // Hold reset 3 cycles and release it on a falling edge
   task automatic apply_reset(input logic [4:0] p, input logic [2:0] bb);
      arst_n   = 1'b0;
      prn      = p;                              // PRN only taken under reset
      baseband = bb;
      view_cnt = 1'b0;
      repeat (3) begin
         @(negedge clk_sample);
         check_idle();
      end
      arst_n = 1'b1;
      #1 check_idle();                           // Nothing moves before the first edge
   endtask

   // Poll on falling edges while the view flips at random
   task automatic wait_dump(input logic [15:0] held);
      int n;
      logic shown_cnt;
      n = 0;
      while (dump !== 1'b1) begin
         if (n == DUMP_TIMEOUT) begin
            $display("Timed out after %0d cycles waiting for a dump pulse", DUMP_TIMEOUT);
            $display("TEST FAIL");
            $fatal(1, "dump wait timed out");
         end
         shown_cnt = view_cnt;                   // View taken at the coming edge
         @(negedge clk_sample);
         if (shown_cnt) begin
            check_digits(16'(cyc - 1));          // Count from before that edge
         end else begin
            check_digits(held);                  // Last dump still held
         end
         rnd      = $random(seed);
         view_cnt = rnd[0];
         n++;
      end
   endtask

   task automatic run_case(input int p, input logic [2:0] bb, input logic [9:0] chips,
                           input int exp);
      int v;
      int i;
      logic [15:0] exp16;
      v = bb[2] ? -int'(bb[1:0]) : int'(bb[1:0]);   // Sign-magnitude value
      check_value("dump in data file", -4 * v, exp); // 512 ones against 511 zeros
      exp16 = 16'(exp);
      apply_reset(5'(p), bb);
      @(negedge clk_sample);
      check_value("dump", 0, int'(dump));
      check_value("accumulator", 0, int'(accumulator));
      check_digits(16'h0000);                         // Display live with the zero sum
      check_prn(p);
      for (i = 0; i < 10; i++) begin
         check_value("ca_bit", int'(chips[9 - i]), int'(ca_bit));   // First chip leftmost
         check_value("code_phase.chip", i, int'(code_phase.chip));
         check_value("code_phase.sub", 1, int'(code_phase.sub));    // One sample into chip
         repeat (4) @(negedge clk_sample);
      end
      wait_dump(16'h0000);
      check_value("first dump cycle", PERIOD, cyc);   // Epoch sample plus one cycle
      check_value("accumulator", exp, int'(accumulator));
      check_value("code_phase.chip", 0, int'(code_phase.chip));     // Wrapped to chip 0
      check_value("code_phase.sub", 0, int'(code_phase.sub));
      view_cnt = 1'b0;
      @(negedge clk_sample);
      check_value("dump", 0, int'(dump));            // Single-cycle pulse
      @(negedge clk_sample);
      check_digits(exp16);
      check_prn(p);
      view_cnt = 1'b1;
      repeat (2) @(negedge clk_sample);
      check_digits(16'(cyc - 1));                     // Mux register lags one cycle
      wait_dump(exp16);
      check_value("second dump cycle", 2 * PERIOD, cyc);
      check_value("accumulator", exp, int'(accumulator));
   endtask

   initial begin
      int fd;
      int got;
      int n_cases;
      int f_prn;
      int f_exp;
      logic [2:0] f_bb;
      logic [9:0] f_chips;
      string line;
      arst_n   = 1'b0;
      prn      = '0;
      baseband = '0;
      view_cnt = 1'b0;
      seed     = 32'h3246;
      rnd      = 0;
      n_cases  = 0;
      fd = $fopen("verif/track_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the input data file verif/track_input.txt");
         $display("TEST FAIL");
         $fatal(1, "missing data file");
      end
      while (!$feof(fd)) begin
         line = "";
         got  = $fgets(line, fd);
         if (got != 0 && line.len() > 1 && line.getc(0) != "#") begin   // Skip comment lines
            if ($sscanf(line, "%d %h %b %d", f_prn, f_bb, f_chips, f_exp) != 4) begin
               $display("Malformed line in the input data file: %s", line);
               $display("TEST FAIL");
               $fatal(1, "bad data line");
            end
            run_case(f_prn, f_bb, f_chips, f_exp);
            n_cases++;
         end
      end
      $fclose(fd);
      if (n_cases > 0) begin
         $display("Ran %0d cases", n_cases);
         $display("TEST PASS");
         $finish;
      end else begin
         $display("The input data file held no test cases");
         $display("TEST FAIL");
         $fatal(1, "no cases");
      end
   end

endmodule

`default_nettype wire

// ==== verif/track_input.txt ====
# prn(decimal)  baseband(hex, bit 2 sign, bits 1:0 mag)  first ten chips  expected dump
# the dump is -4 times the sample value since each period has one more 1 chip than 0 chips
1  3 1100100000 -12
2  7 1110010000 12
3  1 1111001000 -4
4  5 1111100100 4
5  2 1001011011 -8
6  6 1100101101 8
7  0 1001011001 0
8  4 1100101100 0
9  3 1110010110 -12
10 7 1101000100 12
11 1 1110100010 -4
12 2 1111101000 -8
13 6 1111110100 8
14 5 1111111010 4
15 3 1111111101 -12
16 7 1111111110 12
17 0 1001101110 0
19 2 1110011011 -8
21 6 1111100110 8
23 1 1000110011 -4
24 5 1111000110 4
31 3 1110010101 -12

// ==== verilog.f ====
logic/gps_pkg.sv
logic/hex_driver.sv
logic/ca_code_gen.sv
logic/ca_upsampler.sv
logic/code_correlator.sv
logic/gps_display.sv
logic/gps_track_top.sv
verif/tb_gps_track.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the tracking testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module tb_gps_track -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
